//--- all.f
+incdir+source
source/ra_pkg.sv
source/gpr_file.sv
source/seg_file.sv
source/reg_scoreboard.sv
source/stack_tracker.sv
source/reg_access_stage.sv
testbench/tb_reg_access.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_reg_access -f all.f -o tb_reg_access \
    && ./obj_dir/tb_reg_access > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation finished: PASS" sim.log \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

//--- source/gpr_file.sv
// General register file of eight 32-bit registers with sized writeback.
// Also applies the movs step to ESI and EDI; a same-cycle writeback wins.
`default_nettype none
`timescale 1ns/1ps

`include "ra_defines.svh"

module gpr_file (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    wr_en,
    input  wire logic [`RA_REGNUM_W-1:0] wr_num,
    input  wire ra_pkg::acc_size_t       wr_size,
    input  wire logic [`RA_DATA_W-1:0]   wr_data,
    input  wire logic                    str_en,
    input  wire logic                    str_down,
    input  wire ra_pkg::acc_size_t       str_size,
    input  wire logic [`RA_REGNUM_W-1:0] rd0_num,
    input  wire logic [`RA_REGNUM_W-1:0] rd1_num,
    output logic [`RA_DATA_W-1:0]        rd0_data,
    output logic [`RA_DATA_W-1:0]        rd1_data,
    output logic [`RA_DATA_W-1:0]        esp_out
);
    import ra_pkg::*;

    logic [`RA_DATA_W-1:0] regs [`RA_NREG];
    logic [`RA_DATA_W-1:0] str_step;
    logic [`RA_DATA_W-1:0] wr_merged;
    logic [`RA_DATA_W-1:0] wr_old;

    assign str_step = step_bytes(str_size);
    assign wr_old   = regs[wr_num];

    // Byte and word writes keep the upper bits of the old value
    always_comb begin
        case (wr_size)
            SZ_BYTE:  wr_merged = {wr_old[`RA_DATA_W-1:8], wr_data[7:0]};
            SZ_WORD:  wr_merged = {wr_old[`RA_DATA_W-1:16], wr_data[15:0]};
            SZ_DWORD: wr_merged = wr_data;
            default:  wr_merged = wr_old;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RA_NREG; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (str_en) begin
                if (str_down) begin
                    regs[`RA_ESI] <= regs[`RA_ESI] - str_step;
                    regs[`RA_EDI] <= regs[`RA_EDI] - str_step;
                end else begin
                    regs[`RA_ESI] <= regs[`RA_ESI] + str_step;
                    regs[`RA_EDI] <= regs[`RA_EDI] + str_step;
                end
            end
            // Placed last so it overrides the string step
            if (wr_en) begin
                regs[wr_num] <= wr_merged;
            end
        end
    end

    assign rd0_data = regs[rd0_num];
    assign rd1_data = regs[rd1_num];
    assign esp_out  = regs[`RA_ESP];

    // Execute must always report how wide its result is
    a_wr_size_known: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> wr_size != SZ_NONE);

endmodule

`default_nettype wire

//--- source/ra_defines.svh
// Widths, register numbers and encodings shared by the register access stage.
// Include after the timescale in any file that sizes a port or picks a register.
`ifndef RA_DEFINES_SVH
`define RA_DEFINES_SVH

// Register widths
`define RA_DATA_W 32
`define RA_SEG_W 16

// General register file geometry
`define RA_NREG 8
`define RA_REGNUM_W 3

// Up to three writes in flight per register
`define RA_CNT_W 2

// General register numbers used by stack and string logic
`define RA_ESP 3'd4
`define RA_ESI 3'd6
`define RA_EDI 3'd7

// Segment numbering is ES 0, CS 1, SS 2, DS 3, FS 4, GS 5
`define RA_NSEG 6
`define RA_SEG_CS 3'd1
`define RA_SEG_SS 3'd2
`define RA_SEG_DS 3'd3

// Operand kind that takes its register from modrm rm
`define RA_KIND_RM 3'd4

`endif

//--- source/ra_pkg.sv
// Operand kind, stack operation and access size types for the register access stage.
// Modules import this package inside their body and use scoped names in port lists.
`default_nettype none

`include "ra_defines.svh"

package ra_pkg;

    // What an operand of the decoded instruction is
    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_REG  = 3'd1,
        OP_IMM  = 3'd2,
        OP_MEM  = 3'd3,
        OP_RM   = `RA_KIND_RM,
        OP_SEG  = 3'd5
    } op_kind_t;

    typedef enum logic [1:0] {
        STK_NONE = 2'd0,
        STK_PUSH = 2'd1,
        STK_POP  = 2'd2
    } stack_op_t;

    typedef enum logic [1:0] {
        SZ_NONE  = 2'd0,
        SZ_BYTE  = 2'd1,
        SZ_WORD  = 2'd2,
        SZ_DWORD = 2'd3
    } acc_size_t;

    // Byte step for stack and string pointer updates
    function automatic logic [`RA_DATA_W-1:0] step_bytes(input acc_size_t size);
        case (size)
            SZ_BYTE:  return `RA_DATA_W'd1;
            SZ_WORD:  return `RA_DATA_W'd2;
            SZ_DWORD: return `RA_DATA_W'd4;
            default:  return '0;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- source/reg_access_stage.sv
// Register access stage between decode and address generation.
// Resolves operand registers, stalls on pending writes, reads the register files
// and registers the result for one cycle behind a valid/ready handshake.
`default_nettype none
`timescale 1ns/1ps

`include "ra_defines.svh"

module reg_access_stage (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    flush,
    input  wire logic                    flag_df,
    input  wire logic [`RA_SEG_W-1:0]    write_cs,
    input  wire logic                    write_cs_enable,

    // Decode side
    input  wire logic                    d_valid,
    output logic                         d_ready,
    input  wire ra_pkg::acc_size_t       d_size,
    input  wire ra_pkg::op_kind_t        d_op0_kind,
    input  wire ra_pkg::op_kind_t        d_op1_kind,
    input  wire logic [`RA_REGNUM_W-1:0] d_op0_reg,
    input  wire logic [`RA_REGNUM_W-1:0] d_op1_reg,
    input  wire logic [7:0]              d_modrm,
    input  wire logic [`RA_REGNUM_W-1:0] d_dest_reg,
    input  wire logic                    d_dest_en,
    input  wire ra_pkg::stack_op_t       d_stack_op,
    input  wire logic                    d_movs,
    input  wire logic [2:0]              d_seg_override,
    input  wire logic                    d_seg_override_valid,

    // Address generation side
    output logic                         r_valid,
    input  wire logic                    r_ready,
    output logic [`RA_REGNUM_W-1:0]      r_op0_reg,
    output logic [`RA_REGNUM_W-1:0]      r_op1_reg,
    output logic [`RA_DATA_W-1:0]        r_op0_value,
    output logic [`RA_DATA_W-1:0]        r_op1_value,
    output logic [`RA_SEG_W-1:0]         r_seg_value,
    output logic [`RA_DATA_W-1:0]        r_stack_address,
    output ra_pkg::acc_size_t            r_size,
    output ra_pkg::stack_op_t            r_stack_op,

    // Writeback
    input  wire logic                    wb_reg_en,
    input  wire logic [`RA_REGNUM_W-1:0] wb_reg_number,
    input  wire ra_pkg::acc_size_t       wb_reg_size,
    input  wire logic [`RA_DATA_W-1:0]   wb_reg_data,
    input  wire logic                    wb_stack,
    input  wire logic                    wb_seg_en,
    input  wire logic [2:0]              wb_seg_number,
    input  wire logic [`RA_SEG_W-1:0]    wb_seg_data
);
    import ra_pkg::*;

    logic                    accept;
    logic                    hazard;
    logic                    out_free;
    logic [`RA_REGNUM_W-1:0] op0_num;
    logic [`RA_REGNUM_W-1:0] op1_num;
    logic                    chk0_en;
    logic                    chk1_en;
    logic                    chk_esp;
    logic                    chk_str;
    logic [`RA_DATA_W-1:0]   op0_value;
    logic [`RA_DATA_W-1:0]   op1_value;
    logic [`RA_DATA_W-1:0]   esp_commit;
    logic [`RA_DATA_W-1:0]   stack_address;
    logic [2:0]              seg_sel;
    logic [`RA_SEG_W-1:0]    seg_value;
    logic [`RA_SEG_W-1:0]    ss_value;

    // rm-kind operands name their register in modrm bits 2:0
    assign op0_num = (d_op0_kind == OP_RM) ? d_modrm[2:0] : d_op0_reg;
    assign op1_num = (d_op1_kind == OP_RM) ? d_modrm[2:0] : d_op1_reg;

    // Only register operands read the general file
    assign chk0_en = d_valid && (d_op0_kind == OP_REG || d_op0_kind == OP_RM);
    assign chk1_en = d_valid && (d_op1_kind == OP_REG || d_op1_kind == OP_RM);
    assign chk_esp = d_valid && (d_stack_op != STK_NONE);
    assign chk_str = d_valid && d_movs;

    assign seg_sel = d_seg_override_valid ? d_seg_override : `RA_SEG_DS;

    // Handshake
    assign out_free = !r_valid || r_ready;
    assign d_ready  = out_free && !hazard;
    assign accept   = d_valid && d_ready;

    gpr_file u_gpr (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (wb_reg_en),
        .wr_num   (wb_reg_number),
        .wr_size  (wb_reg_size),
        .wr_data  (wb_reg_data),
        .str_en   (accept && d_movs),
        .str_down (flag_df),
        .str_size (d_size),
        .rd0_num  (op0_num),
        .rd1_num  (op1_num),
        .rd0_data (op0_value),
        .rd1_data (op1_value),
        .esp_out  (esp_commit)
    );

    seg_file u_seg (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wb_seg_en),
        .wr_num  (wb_seg_number),
        .wr_data (wb_seg_data),
        .cs_data (write_cs),
        .cs_en   (write_cs_enable),
        .rd_num  (seg_sel),
        .rd_data (seg_value),
        .ss_out  (ss_value)
    );

    reg_scoreboard u_sb (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .issue_en   (accept && d_dest_en),
        .issue_num  (d_dest_reg),
        .retire_en  (wb_reg_en),
        .retire_num (wb_reg_number),
        .chk0_en    (chk0_en),
        .chk0_num   (op0_num),
        .chk1_en    (chk1_en),
        .chk1_num   (op1_num),
        .chk_esp    (chk_esp),
        .chk_str    (chk_str),
        .hazard     (hazard)
    );

    stack_tracker u_stack (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .ss_sel        (ss_value),
        .esp_commit    (esp_commit),
        .accept        (accept),
        .op            (d_stack_op),
        .size          (d_size),
        .wb_en         (wb_reg_en),
        .wb_num        (wb_reg_number),
        .wb_stack      (wb_stack),
        .wb_data       (wb_reg_data),
        .stack_address (stack_address)
    );

    // Output register valid
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            r_valid <= 1'b0;
        end else if (accept) begin
            r_valid <= 1'b1;
        end else if (r_ready) begin
            r_valid <= 1'b0;
        end
    end

    // Payload loads only on accept and holds under back-pressure
    always_ff @(posedge clk) begin
        if (accept) begin
            r_op0_reg       <= op0_num;
            r_op1_reg       <= op1_num;
            r_op0_value     <= op0_value;
            r_op1_value     <= op1_value;
            r_seg_value     <= seg_value;
            r_stack_address <= stack_address;
            r_size          <= d_size;
            r_stack_op      <= d_stack_op;
        end
    end

endmodule

`default_nettype wire

//--- source/reg_scoreboard.sv
// Pending-write counters for the general registers.
// Issue counts a write up, writeback counts it down; nonzero on a checked register stalls.
`default_nettype none
`timescale 1ns/1ps

`include "ra_defines.svh"

module reg_scoreboard (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    flush,
    input  wire logic                    issue_en,
    input  wire logic [`RA_REGNUM_W-1:0] issue_num,
    input  wire logic                    retire_en,
    input  wire logic [`RA_REGNUM_W-1:0] retire_num,
    input  wire logic                    chk0_en,
    input  wire logic [`RA_REGNUM_W-1:0] chk0_num,
    input  wire logic                    chk1_en,
    input  wire logic [`RA_REGNUM_W-1:0] chk1_num,
    input  wire logic                    chk_esp,
    input  wire logic                    chk_str,
    output logic                         hazard
);

    logic [`RA_CNT_W-1:0] cnt [`RA_NREG];
    logic [`RA_NREG-1:0]  inc;
    logic [`RA_NREG-1:0]  dec;
    logic [`RA_NREG-1:0]  busy;

    always_comb begin
        for (int i = 0; i < `RA_NREG; i++) begin
            inc[i]  = issue_en && (issue_num == `RA_REGNUM_W'(i));
            dec[i]  = retire_en && (retire_num == `RA_REGNUM_W'(i));
            busy[i] = cnt[i] != '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int i = 0; i < `RA_NREG; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `RA_NREG; i++) begin
                // Issue and retire together cancel out
                if (inc[i] && !dec[i]) begin
                    cnt[i] <= cnt[i] + 1'b1;
                end else if (dec[i] && !inc[i]) begin
                    cnt[i] <= cnt[i] - 1'b1;
                end
            end
        end
    end

    // Stack ops read ESP, movs reads ESI and EDI
    assign hazard = (chk0_en && busy[chk0_num])
                 || (chk1_en && busy[chk1_num])
                 || (chk_esp && busy[`RA_ESP])
                 || (chk_str && (busy[`RA_ESI] || busy[`RA_EDI]));

    // More than three writes in flight to one register is not supported
    a_no_overflow: assert property (@(posedge clk) disable iff (rst || flush)
        (issue_en && !(retire_en && retire_num == issue_num))
        |-> cnt[issue_num] != '1);

    // Every writeback must match an earlier issue
    a_no_orphan_retire: assert property (@(posedge clk) disable iff (rst || flush)
        retire_en |-> busy[retire_num]);

endmodule

`default_nettype wire

//--- source/seg_file.sv
// Six 16-bit segment registers, written back from the pipe or directly for CS.
// Reads one selected register combinationally and always presents SS.
`default_nettype none
`timescale 1ns/1ps

`include "ra_defines.svh"

module seg_file (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  wr_en,
    input  wire logic [2:0]            wr_num,
    input  wire logic [`RA_SEG_W-1:0]  wr_data,
    input  wire logic [`RA_SEG_W-1:0]  cs_data,
    input  wire logic                  cs_en,
    input  wire logic [2:0]            rd_num,
    output logic [`RA_SEG_W-1:0]       rd_data,
    output logic [`RA_SEG_W-1:0]       ss_out
);

    logic [`RA_SEG_W-1:0] segs [`RA_NSEG];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RA_NSEG; i++) begin
                segs[i] <= '0;
            end
        end else begin
            if (wr_en && wr_num < 3'(`RA_NSEG)) begin
                segs[wr_num] <= wr_data;
            end
            // Far jump loads CS directly and beats any writeback
            if (cs_en) begin
                segs[`RA_SEG_CS] <= cs_data;
            end
        end
    end

    // Numbers 6 and 7 name no segment
    assign rd_data = (rd_num < 3'(`RA_NSEG)) ? segs[rd_num] : '0;
    assign ss_out  = segs[`RA_SEG_SS];

    a_wr_num_valid: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> wr_num < 3'(`RA_NSEG));

endmodule

`default_nettype wire

//--- source/stack_tracker.sv
// Speculative working ESP and the linear push/pop address derived from it.
// The real-mode base is the SS selector shifted left by four.
`default_nettype none
`timescale 1ns/1ps

`include "ra_defines.svh"

module stack_tracker (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    flush,
    input  wire logic [`RA_SEG_W-1:0]    ss_sel,
    input  wire logic [`RA_DATA_W-1:0]   esp_commit,
    input  wire logic                    accept,
    input  wire ra_pkg::stack_op_t       op,
    input  wire ra_pkg::acc_size_t       size,
    input  wire logic                    wb_en,
    input  wire logic [`RA_REGNUM_W-1:0] wb_num,
    input  wire logic                    wb_stack,
    input  wire logic [`RA_DATA_W-1:0]   wb_data,
    output logic [`RA_DATA_W-1:0]        stack_address
);
    import ra_pkg::*;

    logic [`RA_DATA_W-1:0] work_esp;
    logic [`RA_DATA_W-1:0] step;
    logic [`RA_DATA_W-1:0] seg_base;
    logic [`RA_DATA_W-1:0] push_esp;
    logic [`RA_DATA_W-1:0] pop_esp;
    logic                  esp_overwrite;

    assign step     = step_bytes(size);
    assign seg_base = {{(`RA_DATA_W - `RA_SEG_W - 4){1'b0}}, ss_sel, 4'b0000};
    assign push_esp = work_esp - step;
    assign pop_esp  = work_esp + step;

    // Push stores below the current top, pop reads the current top
    assign stack_address = seg_base + ((op == STK_PUSH) ? push_esp : work_esp);

    // A write to ESP that stack tracking did not produce (mov esp, ...)
    assign esp_overwrite = wb_en && (wb_num == `RA_ESP) && !wb_stack;

    always_ff @(posedge clk) begin
        if (rst) begin
            work_esp <= '0;
        end else if (flush) begin
            work_esp <= esp_commit;
        end else if (esp_overwrite) begin
            work_esp <= wb_data;
        end else if (accept) begin
            case (op)
                STK_PUSH: work_esp <= push_esp;
                STK_POP:  work_esp <= pop_esp;
                default:  work_esp <= work_esp;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_reg_access.sv
// Table-driven testbench for the register access stage.
// A reference register model fills in the expected operand values, segment
// selectors and stack addresses while the table is built, then the table is replayed.
`default_nettype none
`timescale 1ns/1ps

`include "ra_defines.svh"

module tb_reg_access;
    import ra_pkg::*;

    localparam int TIMEOUT = 50;

    typedef struct packed {
        logic        flush;
        logic        hold;
        logic        wb_en;
        logic [2:0]  wb_num;
        logic [1:0]  wb_size;
        logic [31:0] wb_data;
        logic        wb_stack;
        logic        wb_late;
        logic        seg_en;
        logic [2:0]  seg_num;
        logic [15:0] seg_data;
        logic [1:0]  size;
        logic [2:0]  k0;
        logic [2:0]  r0;
        logic [2:0]  k1;
        logic [2:0]  r1;
        logic [7:0]  modrm;
        logic        dest_en;
        logic [2:0]  dest;
        logic [1:0]  stk;
        logic        movs;
        logic        df;
        logic        ovr_v;
        logic [2:0]  ovr;
        logic [2:0]  e_reg0;
        logic [2:0]  e_reg1;
        logic [31:0] e_val0;
        logic [31:0] e_val1;
        logic [15:0] e_seg;
        logic [31:0] e_addr;
    } entry_t;

    logic        clk;
    logic        rst;
    logic        flush;
    logic        flag_df;
    logic [15:0] write_cs;
    logic        write_cs_enable;
    logic        d_valid;
    logic        d_ready;
    acc_size_t   d_size;
    op_kind_t    d_op0_kind;
    op_kind_t    d_op1_kind;
    logic [2:0]  d_op0_reg;
    logic [2:0]  d_op1_reg;
    logic [7:0]  d_modrm;
    logic [2:0]  d_dest_reg;
    logic        d_dest_en;
    stack_op_t   d_stack_op;
    logic        d_movs;
    logic [2:0]  d_seg_override;
    logic        d_seg_override_valid;
    logic        r_valid;
    logic        r_ready;
    logic [2:0]  r_op0_reg;
    logic [2:0]  r_op1_reg;
    logic [31:0] r_op0_value;
    logic [31:0] r_op1_value;
    logic [15:0] r_seg_value;
    logic [31:0] r_stack_address;
    acc_size_t   r_size;
    stack_op_t   r_stack_op;
    logic        wb_reg_en;
    logic [2:0]  wb_reg_number;
    acc_size_t   wb_reg_size;
    logic [31:0] wb_reg_data;
    logic        wb_stack;
    logic        wb_seg_en;
    logic [2:0]  wb_seg_number;
    logic [15:0] wb_seg_data;

    // Reference model state and the stimulus table
    logic [31:0] m_regs [8];
    logic [15:0] m_segs [6];
    logic [31:0] m_wesp;
    logic [31:0] lcg_state;
    entry_t      cur;
    entry_t      tbl [64];
    int          n_entries;
    int          value_errors;
    int          timeouts;

    reg_access_stage UUT (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Byte, word and dword pointer steps
    function automatic logic [31:0] size_bytes(input logic [1:0] size);
        case (size)
            2'd1:    return 32'd1;
            2'd2:    return 32'd2;
            2'd3:    return 32'd4;
            default: return 32'd0;
        endcase
    endfunction

    // Narrow writes keep the upper bits
    function automatic logic [31:0] merge_write(input logic [31:0] old, input logic [31:0] data,
                                                input logic [1:0] size);
        case (size)
            2'd1:    return {old[31:8], data[7:0]};
            2'd2:    return {old[31:16], data[15:0]};
            default: return data;
        endcase
    endfunction

    task automatic set_wb(input logic [2:0] num, input acc_size_t size, input logic stack,
                          input logic late);
        lcg_state = lcg_next(lcg_state);
        cur.wb_en = 1'b1;
        cur.wb_num = num;
        cur.wb_size = size;
        cur.wb_data = lcg_state;
        cur.wb_stack = stack;
        cur.wb_late = late;
    endtask

    task automatic set_seg(input logic [2:0] num);
        lcg_state = lcg_next(lcg_state);
        cur.seg_en = 1'b1;
        cur.seg_num = num;
        cur.seg_data = lcg_state[31:16];
    endtask

    task automatic add_instr(input acc_size_t size, input op_kind_t k0, input logic [2:0] r0,
                             input op_kind_t k1, input logic [2:0] r1, input logic [7:0] modrm,
                             input logic dest_en, input logic [2:0] dest, input stack_op_t stk,
                             input logic movs, input logic df);
        logic [2:0]  n0;
        logic [2:0]  n1;
        logic [31:0] step;
        logic [31:0] base;
        cur.size = size;
        cur.k0 = k0;
        cur.r0 = r0;
        cur.k1 = k1;
        cur.r1 = r1;
        cur.modrm = modrm;
        cur.dest_en = dest_en;
        cur.dest = dest;
        cur.stk = stk;
        cur.movs = movs;
        cur.df = df;
        // Flush and writebacks land before the accept
        if (cur.flush) begin
            m_wesp = m_regs[`RA_ESP];
        end
        if (cur.wb_en) begin
            m_regs[cur.wb_num] = merge_write(m_regs[cur.wb_num], cur.wb_data, cur.wb_size);
            if (cur.wb_num == `RA_ESP && !cur.wb_stack) begin
                m_wesp = cur.wb_data;
            end
        end
        if (cur.seg_en) begin
            m_segs[cur.seg_num] = cur.seg_data;
        end
        n0 = (k0 == OP_RM) ? modrm[2:0] : r0;
        n1 = (k1 == OP_RM) ? modrm[2:0] : r1;
        cur.e_reg0 = n0;
        cur.e_reg1 = n1;
        cur.e_val0 = m_regs[n0];
        cur.e_val1 = m_regs[n1];
        cur.e_seg = cur.ovr_v ? m_segs[cur.ovr] : m_segs[`RA_SEG_DS];
        step = size_bytes(size);
        base = {12'b0, m_segs[`RA_SEG_SS], 4'b0};
        cur.e_addr = base + ((stk == STK_PUSH) ? m_wesp - step : m_wesp);
        // Pointer updates that the accept causes
        if (movs) begin
            m_regs[`RA_ESI] = df ? m_regs[`RA_ESI] - step : m_regs[`RA_ESI] + step;
            m_regs[`RA_EDI] = df ? m_regs[`RA_EDI] - step : m_regs[`RA_EDI] + step;
        end
        if (stk == STK_PUSH) begin
            m_wesp = m_wesp - step;
        end else if (stk == STK_POP) begin
            m_wesp = m_wesp + step;
        end
        tbl[n_entries] = cur;
        n_entries++;
        cur = '0;
    endtask

    task automatic build_table();
        // First push right after reset
        add_instr(SZ_DWORD, OP_NONE, 3'd0, OP_NONE, 3'd0, 8'h00, 1'b0, 3'd0, STK_PUSH, 1'b0, 1'b0);
        // Dword, word and byte writes to EBX
        add_instr(SZ_DWORD, OP_NONE, 3'd0, OP_NONE, 3'd0, 8'h00, 1'b1, 3'd3, STK_NONE, 1'b0, 1'b0);
        set_wb(3'd3, SZ_DWORD, 1'b0, 1'b0);
        add_instr(SZ_DWORD, OP_REG, 3'd3, OP_RM, 3'd0, 8'hC3, 1'b1, 3'd3, STK_NONE, 1'b0, 1'b0);
        set_wb(3'd3, SZ_WORD, 1'b0, 1'b0);
        add_instr(SZ_WORD, OP_RM, 3'd5, OP_REG, 3'd3, 8'hD3, 1'b1, 3'd3, STK_NONE, 1'b0, 1'b0);
        set_wb(3'd3, SZ_BYTE, 1'b0, 1'b0);
        add_instr(SZ_BYTE, OP_REG, 3'd3, OP_RM, 3'd0, 8'h1B, 1'b0, 3'd0, STK_NONE, 1'b0, 1'b0);
        // Readers stall until the pending write comes back
        add_instr(SZ_DWORD, OP_NONE, 3'd0, OP_NONE, 3'd0, 8'h00, 1'b1, 3'd1, STK_NONE, 1'b0, 1'b0);
        set_wb(3'd1, SZ_DWORD, 1'b0, 1'b1);
        add_instr(SZ_DWORD, OP_REG, 3'd1, OP_REG, 3'd3, 8'h00, 1'b0, 3'd0, STK_NONE, 1'b0, 1'b0);
        add_instr(SZ_DWORD, OP_NONE, 3'd0, OP_NONE, 3'd0, 8'h00, 1'b1, 3'd2, STK_NONE, 1'b0, 1'b0);
        set_wb(3'd2, SZ_DWORD, 1'b0, 1'b1);
        add_instr(SZ_DWORD, OP_REG, 3'd0, OP_RM, 3'd0, 8'hC2, 1'b0, 3'd0, STK_NONE, 1'b0, 1'b0);
        // Mixed pushes and pops on a nonzero SS
        set_seg(`RA_SEG_SS);
        add_instr(SZ_WORD, OP_NONE, 3'd0, OP_NONE, 3'd0, 8'h00, 1'b0, 3'd0, STK_PUSH, 1'b0, 1'b0);
        set_seg(`RA_SEG_DS);
        add_instr(SZ_WORD, OP_NONE, 3'd0, OP_NONE, 3'd0, 8'h00, 1'b0, 3'd0, STK_POP, 1'b0, 1'b0);
        cur.ovr_v = 1'b1;
        cur.ovr = `RA_SEG_SS;
        add_instr(SZ_DWORD, OP_NONE, 3'd0, OP_NONE, 3'd0, 8'h00, 1'b0, 3'd0, STK_PUSH, 1'b0, 1'b0);
        add_instr(SZ_BYTE, OP_NONE, 3'd0, OP_NONE, 3'd0, 8'h00, 1'b0, 3'd0, STK_POP, 1'b0, 1'b0);
        // mov esp restarts the stack sequence
        add_instr(SZ_DWORD, OP_NONE, 3'd0, OP_NONE, 3'd0, 8'h00, 1'b1, `RA_ESP, STK_NONE, 1'b0, 1'b0);
        set_wb(`RA_ESP, SZ_DWORD, 1'b0, 1'b0);
        add_instr(SZ_DWORD, OP_NONE, 3'd0, OP_NONE, 3'd0, 8'h00, 1'b0, 3'd0, STK_PUSH, 1'b0, 1'b0);
        add_instr(SZ_WORD, OP_NONE, 3'd0, OP_NONE, 3'd0, 8'h00, 1'b0, 3'd0, STK_POP, 1'b0, 1'b0);
        // Tracked stack writeback only commits ESP
        add_instr(SZ_DWORD, OP_NONE, 3'd0, OP_NONE, 3'd0, 8'h00, 1'b1, `RA_ESP, STK_PUSH, 1'b0, 1'b0);
        set_wb(`RA_ESP, SZ_DWORD, 1'b1, 1'b0);
        add_instr(SZ_DWORD, OP_NONE, 3'd0, OP_NONE, 3'd0, 8'h00, 1'b0, 3'd0, STK_POP, 1'b0, 1'b0);
        // movs up, then down
        add_instr(SZ_BYTE, OP_REG, `RA_ESI, OP_REG, `RA_EDI, 8'h00, 1'b0, 3'd0, STK_NONE, 1'b1, 1'b0);
        add_instr(SZ_WORD, OP_REG, `RA_ESI, OP_REG, `RA_EDI, 8'h00, 1'b0, 3'd0, STK_NONE, 1'b1, 1'b0);
        add_instr(SZ_DWORD, OP_REG, `RA_ESI, OP_REG, `RA_EDI, 8'h00, 1'b0, 3'd0, STK_NONE, 1'b1, 1'b0);
        add_instr(SZ_DWORD, OP_REG, `RA_ESI, OP_REG, `RA_EDI, 8'h00, 1'b0, 3'd0, STK_NONE, 1'b1, 1'b1);
        add_instr(SZ_BYTE, OP_REG, `RA_ESI, OP_REG, `RA_EDI, 8'h00, 1'b0, 3'd0, STK_NONE, 1'b1, 1'b1);
        add_instr(SZ_DWORD, OP_REG, `RA_ESI, OP_REG, `RA_EDI, 8'h00, 1'b0, 3'd0, STK_NONE, 1'b0, 1'b0);
        // Back-pressure leaves EBP pending, the flush clears it
        cur.hold = 1'b1;
        add_instr(SZ_DWORD, OP_REG, 3'd3, OP_REG, 3'd1, 8'h00, 1'b1, 3'd5, STK_NONE, 1'b0, 1'b0);
        cur.flush = 1'b1;
        add_instr(SZ_DWORD, OP_REG, 3'd5, OP_RM, 3'd0, 8'hC5, 1'b0, 3'd0, STK_PUSH, 1'b0, 1'b0);
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp, input int idx);
        if (got !== exp) begin
            $display("Error: %s = %h, expected %h (entry %0d)", name, got, exp, idx);
            value_errors++;
        end
    endtask

    task automatic check_outputs(input entry_t e, input int idx);
        check_word("r_op0_reg", {29'b0, r_op0_reg}, {29'b0, e.e_reg0}, idx);
        check_word("r_op1_reg", {29'b0, r_op1_reg}, {29'b0, e.e_reg1}, idx);
        check_word("r_op0_value", r_op0_value, e.e_val0, idx);
        check_word("r_op1_value", r_op1_value, e.e_val1, idx);
        check_word("r_seg_value", {16'b0, r_seg_value}, {16'b0, e.e_seg}, idx);
        check_word("r_stack_address", r_stack_address, e.e_addr, idx);
        check_word("r_size", {30'b0, r_size}, {30'b0, e.size}, idx);
        check_word("r_stack_op", {30'b0, r_stack_op}, {30'b0, e.stk}, idx);
    endtask

    task automatic drive_wb(input entry_t e);
        wb_reg_en = 1'b1;
        wb_reg_number = e.wb_num;
        wb_reg_size = acc_size_t'(e.wb_size);
        wb_reg_data = e.wb_data;
        wb_stack = e.wb_stack;
    endtask

    task automatic run_entry(input int i);
        entry_t e;
        int     cnt;
        e = tbl[i];
        if (e.flush) begin
            flush = 1'b1;
            @(negedge clk);
            flush = 1'b0;
            if (r_valid !== 1'b0) begin
                $display("Error: r_valid = %h after flush, expected 0 (entry %0d)", r_valid, i);
                value_errors++;
            end
        end
        r_ready = !e.hold;
        if (e.seg_en || (e.wb_en && !e.wb_late)) begin
            wb_seg_en = e.seg_en;
            wb_seg_number = e.seg_num;
            wb_seg_data = e.seg_data;
            if (e.wb_en) begin
                drive_wb(e);
            end
            @(negedge clk);
            wb_seg_en = 1'b0;
            wb_reg_en = 1'b0;
            wb_stack = 1'b0;
        end
        d_size = acc_size_t'(e.size);
        d_op0_kind = op_kind_t'(e.k0);
        d_op1_kind = op_kind_t'(e.k1);
        d_op0_reg = e.r0;
        d_op1_reg = e.r1;
        d_modrm = e.modrm;
        d_dest_en = e.dest_en;
        d_dest_reg = e.dest;
        d_stack_op = stack_op_t'(e.stk);
        d_movs = e.movs;
        flag_df = e.df;
        d_seg_override = e.ovr;
        d_seg_override_valid = e.ovr_v;
        d_valid = 1'b1;
        // Pending write must hold the reader off
        if (e.wb_late) begin
            repeat (3) begin
                #1;
                if (d_ready !== 1'b0) begin
                    $display("Error: d_ready = %h, expected 0 (entry %0d)", d_ready, i);
                    value_errors++;
                end
                @(negedge clk);
            end
            drive_wb(e);
            @(negedge clk);
            wb_reg_en = 1'b0;
            wb_stack = 1'b0;
        end
        cnt = 0;
        #1;
        while (d_ready !== 1'b1 && cnt < TIMEOUT) begin
            @(negedge clk);
            #1;
            cnt++;
        end
        if (d_ready !== 1'b1) begin
            $display("Timeout: d_ready never rose for entry %0d", i);
            timeouts++;
            return;
        end
        @(negedge clk);
        d_valid = 1'b0;
        cnt = 0;
        while (r_valid !== 1'b1 && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (r_valid !== 1'b1) begin
            $display("Timeout: r_valid never rose for entry %0d", i);
            timeouts++;
            return;
        end
        check_outputs(e, i);
        if (e.hold) begin
            repeat (3) begin
                @(negedge clk);
                check_word("r_valid", {31'b0, r_valid}, 32'h1, i);
                check_word("d_ready", {31'b0, d_ready}, 32'h0, i);
                check_outputs(e, i);
            end
        end else begin
            // Let the output drain
            @(negedge clk);
        end
    endtask

    initial begin
        int i;
        clk = 1'b0;
        rst = 1'b1;
        flush = 1'b0;
        flag_df = 1'b0;
        write_cs = '0;
        write_cs_enable = 1'b0;
        d_valid = 1'b0;
        d_size = SZ_NONE;
        d_op0_kind = OP_NONE;
        d_op1_kind = OP_NONE;
        d_op0_reg = '0;
        d_op1_reg = '0;
        d_modrm = '0;
        d_dest_reg = '0;
        d_dest_en = 1'b0;
        d_stack_op = STK_NONE;
        d_movs = 1'b0;
        d_seg_override = '0;
        d_seg_override_valid = 1'b0;
        r_ready = 1'b1;
        wb_reg_en = 1'b0;
        wb_reg_number = '0;
        wb_reg_size = SZ_NONE;
        wb_reg_data = '0;
        wb_stack = 1'b0;
        wb_seg_en = 1'b0;
        wb_seg_number = '0;
        wb_seg_data = '0;
        for (i = 0; i < 8; i++) begin
            m_regs[i] = '0;
        end
        for (i = 0; i < 6; i++) begin
            m_segs[i] = '0;
        end
        m_wesp = '0;
        lcg_state = 32'h4262;
        cur = '0;
        n_entries = 0;
        value_errors = 0;
        timeouts = 0;
        build_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (r_valid !== 1'b0) begin
            $display("Error: r_valid = %h after reset, expected 0", r_valid);
            value_errors++;
        end
        for (i = 0; i < n_entries && timeouts == 0; i++) begin
            run_entry(i);
        end
        $display("Checks done over %0d entries: %0d value errors, %0d timeouts",
                 n_entries, value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
